//--- testbench/rgb2y_luma_tests.txt
# W name addr data(hex) | P name fmt sb rgb(hex) luma | R name addr value(hex)
# B 0/1 random out_ready | D drain | stall counter reads use the testbench count
R rst_fmt 0 0
R rst_clip_en 1 0
R rst_clip_max 3 3ff
P black888 0 1 000000 0
P white888 0 0 ffffff 1020
P red888 0 0 ff0000 307
P green888 0 0 00ff00 598
P blue888 0 0 0000ff 116
P mix888 0 2 123456 183
P white565 1 1 ffff 1020
P red565 1 0 f800 307
P green565 1 0 07e0 598
P blue565 1 0 001f 116
P mix565 1 2 8410 523
P white1010 2 1 3fffffff 1020
P red1010 2 0 3ff00000 307
P green1010 2 0 000ffc00 598
P blue1010 2 0 000003ff 116
P mix1010 2 2 f20340f03 391
D
R fmt_1010 0 2
W clip_min 2 c8
W clip_max 3 2bc
W clip_on 1 1
R rd_min 2 c8
R rd_max 3 2bc
R rd_clip_en 1 1
P clip_blk 0 1 000000 200
P clip_blue 0 0 0000ff 200
P clip_red 0 0 ff0000 307
P clip_mix 0 0 8040c0 391
P clip_grn 0 0 00ff00 598
P clip_wht 0 2 ffffff 700
D
W clip_off 1 0
W clr_stall 4 0
W clr_pix 5 0
B 1
P bp01 0 1 000000 0
P bp02 0 0 ffffff 1020
P bp03 0 0 ff0000 307
P bp04 0 0 00ff00 598
P bp05 0 0 0000ff 116
P bp06 0 0 123456 183
P bp07 0 0 804080 362
P bp08 0 2 8040c0 391
P bp09 0 1 404040 256
P bp10 0 0 808080 512
P bp11 0 0 c0c0c0 768
P bp12 0 2 010203 7
D
R stall_cnt 4 0
R pix_cnt 5 c
B 0
W clr_stall2 4 0
W clr_pix2 5 0
R stall_zero 4 0
R pix_zero 5 0

//--- rgb2y_luma_top.f
common/rgb2y_pix_pkg.sv
common/rgb2y_cfg_pkg.sv
logic/rgb2y_cfg_regs.sv
rgb2y_luma/rgb2y_unpack.sv
rgb2y_luma/rgb2y_weight_sum.sv
rgb2y_luma/rgb2y_out_pack.sv
rgb2y_luma/rgb2y_luma_top.sv
testbench/rgb2y_luma_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f rgb2y_luma_top.f \
  --top-module rgb2y_luma_tb -o rgb2y_luma_sim
out=$(./obj_dir/rgb2y_luma_sim) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'TEST OK'; then
  echo "simulation passed"
else
  echo "simulation did not pass"
  exit 1
fi

//--- testbench/rgb2y_luma_tb.sv
// rgb2y luma testbench: file-driven pixels and register accesses checked by a scoreboard
`timescale 1ns/100ps

module rgb2y_luma_tb;

  import rgb2y_pix_pkg::*;
  import rgb2y_cfg_pkg::*;

  localparam int unsigned HALF_T   = 20;
  // sample point after the falling edge, well before the rising edge
  localparam int unsigned SAMPLE_T = 10;
  localparam int unsigned WAIT_MAX = 200;
  // accept edge to output transfer edge
  localparam int unsigned LATENCY  = 4;

  // --------------------
  // DUT signals
  // --------------------
  logic                clk;
  logic                arst_n;
  logic                pix_valid;
  logic [RGB_IN_W-1:0] rgb_in;
  logic [SB_W-1:0]     sb_in;
  logic                in_ready;
  logic                out_valid;
  logic                out_ready;
  logic [Y_W-1:0]      y_out;
  logic [SB_W-1:0]     sb_out;
  logic                cfg_we;
  cfg_addr_e           cfg_addr;
  logic [CFG_DW-1:0]   cfg_wdata;
  logic [CFG_DW-1:0]   cfg_rdata;

  // scoreboard, one entry per pixel in flight
  logic [Y_W-1:0]      exp_y_q    [$];
  logic [SB_W-1:0]     exp_sb_q   [$];
  logic [8*16-1:0]     exp_name_q [$];

  integer              seed;
  integer              value_errs;
  integer              other_errs;
  // index of the next rising edge
  integer              edge_idx;
  integer              stall_seen;
  integer              lat_edge;
  logic                lat_pending;
  logic                first_pix;
  logic                bp_on;
  logic [1:0]          cur_fmt;

  rgb2y_luma_top DUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .pix_valid (pix_valid),
    .rgb_in    (rgb_in),
    .sb_in     (sb_in),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .y_out     (y_out),
    .sb_out    (sb_out),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_T clk = ~clk;
  end

  // out_ready, random while back-pressure is on
  initial begin : ready_drive
    integer rnd;
    forever begin
      @(negedge clk);
      rnd = $random(seed);
      out_ready = bp_on ? rnd[0] : 1'b1;
    end
  end

  // --------------------
  // output monitor
  // --------------------
  task automatic check_beat();
    logic [Y_W-1:0]  ey;
    logic [SB_W-1:0] es;
    logic [8*16-1:0] en;
    if (exp_y_q.size() == 0) begin
      $display("output beat with no pixel pending, y_out %0d", y_out);
      other_errs++;
    end else begin
      ey = exp_y_q.pop_front();
      es = exp_sb_q.pop_front();
      en = exp_name_q.pop_front();
      if (y_out !== ey) begin
        $display("ERROR %0s: y expected %0d actual %0d", en, ey, y_out);
        value_errs++;
      end
      if (sb_out !== es) begin
        $display("ERROR %0s: sideband expected %0d actual %0d", en, es, sb_out);
        value_errs++;
      end
      if (lat_pending) begin
        lat_pending = 1'b0;
        if (edge_idx - lat_edge != LATENCY) begin
          $display("first pixel came out after %0d cycles instead of %0d",
                   edge_idx - lat_edge, LATENCY);
          other_errs++;
        end
      end
    end
  endtask

  initial begin : out_monitor
    forever begin
      @(negedge clk);
      edge_idx = edge_idx + 1;
      #SAMPLE_T;
      if (out_valid && !out_ready) begin
        stall_seen++;
      end
      if (out_valid && out_ready) begin
        check_beat();
      end
    end
  end

  // --------------------
  // stimulus tasks
  // --------------------
  // each task starts and ends right at a falling edge
  task automatic reg_write(input integer addr, input logic [CFG_DW-1:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = cfg_addr_e'(addr[2:0]);
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
    // track clear-on-write and the active format
    if (addr == REG_STALL_CNT) begin
      stall_seen = 0;
    end
    if (addr == REG_FMT) begin
      cur_fmt = data[1:0];
    end
  endtask

  task automatic reg_check(input logic [8*16-1:0] name, input integer addr,
                           input logic [CFG_DW-1:0] file_exp);
    logic [CFG_DW-1:0] exp;
    cfg_addr = cfg_addr_e'(addr[2:0]);
    #SAMPLE_T;
    exp = file_exp;
    // stall count depends on the random out_ready
    if (addr == REG_STALL_CNT) begin
      exp = CFG_DW'(stall_seen);
    end
    if (cfg_rdata !== exp) begin
      $display("ERROR %0s: expected %0h actual %0h", name, exp, cfg_rdata);
      value_errs++;
    end
    @(negedge clk);
  endtask

  task automatic send_pixel(input logic [8*16-1:0] name, input logic [RGB_IN_W-1:0] rgb,
                            input logic [SB_W-1:0] sb, input integer exp_y);
    integer waited;
    logic   taken;
    pix_valid = 1'b1;
    rgb_in    = rgb;
    sb_in     = sb;
    exp_y_q.push_back(Y_W'(exp_y));
    exp_sb_q.push_back(sb);
    exp_name_q.push_back(name);
    waited = 0;
    taken  = 1'b0;
    while (!taken && waited < WAIT_MAX) begin
      #SAMPLE_T;
      if (in_ready) begin
        taken = 1'b1;
        // latency measured on the first pixel only
        if (first_pix) begin
          first_pix   = 1'b0;
          lat_edge    = edge_idx;
          lat_pending = 1'b1;
        end
        @(negedge clk);
      end else begin
        waited++;
        @(negedge clk);
      end
    end
    pix_valid = 1'b0;
    if (!taken) begin
      $display("timeout waiting for in_ready on pixel %0s", name);
      other_errs++;
      void'(exp_y_q.pop_back());
      void'(exp_sb_q.pop_back());
      void'(exp_name_q.pop_back());
    end
  endtask

  task automatic drain_all();
    integer waited;
    waited = 0;
    while (exp_y_q.size() != 0 && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
    end
    if (exp_y_q.size() != 0) begin
      $display("timeout draining, %0d pixels never came out", exp_y_q.size());
      other_errs++;
      exp_y_q.delete();
      exp_sb_q.delete();
      exp_name_q.delete();
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin : main_seq
    integer              fd;
    integer              code;
    integer              f_fmt;
    integer              f_sb;
    integer              f_addr;
    integer              f_bp;
    integer              f_y;
    logic [RGB_IN_W-1:0] f_rgb;
    logic [CFG_DW-1:0]   f_data;
    logic [8*16-1:0]     kind;
    logic [8*16-1:0]     name;
    logic [8*128-1:0]    line;
    logic                done;

    seed        = 32'ha8a3_8df2;
    value_errs  = 0;
    other_errs  = 0;
    edge_idx    = 0;
    stall_seen  = 0;
    lat_edge    = 0;
    lat_pending = 1'b0;
    first_pix   = 1'b1;
    bp_on       = 1'b0;
    cur_fmt     = 2'd0;
    arst_n      = 1'b0;
    pix_valid   = 1'b0;
    rgb_in      = '0;
    sb_in       = '0;
    out_ready   = 1'b1;
    cfg_we      = 1'b0;
    cfg_addr    = REG_FMT;
    cfg_wdata   = '0;

    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    #SAMPLE_T;
    if (in_ready !== 1'b1) begin
      $display("in_ready is not high right after reset");
      other_errs++;
    end
    if (out_valid !== 1'b0) begin
      $display("out_valid is not low right after reset");
      other_errs++;
    end
    @(negedge clk);

    fd = $fopen("testbench/rgb2y_luma_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test data file");
      other_errs++;
    end else begin
      done = 1'b0;
      while (!done) begin
        code = $fscanf(fd, "%s", kind);
        if (code != 1) begin
          done = 1'b1;
        end else if (kind == "#") begin
          code = $fgets(line, fd);
        end else if (kind == "W") begin
          code = $fscanf(fd, "%s %d %h", name, f_addr, f_data);
          reg_write(f_addr, f_data);
        end else if (kind == "P") begin
          code = $fscanf(fd, "%s %d %d %h %d", name, f_fmt, f_sb, f_rgb, f_y);
          // format only changes with the pipeline empty
          if (f_fmt != cur_fmt) begin
            drain_all();
            reg_write(REG_FMT, CFG_DW'(f_fmt));
          end
          send_pixel(name, f_rgb, f_sb[SB_W-1:0], f_y);
        end else if (kind == "R") begin
          code = $fscanf(fd, "%s %d %h", name, f_addr, f_data);
          reg_check(name, f_addr, f_data);
        end else if (kind == "B") begin
          code = $fscanf(fd, "%d", f_bp);
          bp_on = (f_bp != 0);
        end else if (kind == "D") begin
          drain_all();
        end else begin
          $display("unknown record kind in the test data file");
          other_errs++;
          done = 1'b1;
        end
      end
      $fclose(fd);
    end
    drain_all();

    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- rgb2y_luma/rgb2y_luma_top.sv
// rgb2y luma top: RGB stream to clipped 10-bit luma stream with config registers
`timescale 1ns/100ps

module rgb2y_luma_top (
  input  logic                               clk,
  input  logic                               arst_n,
  // input pixel stream
  input  logic                               pix_valid,
  input  logic [rgb2y_pix_pkg::RGB_IN_W-1:0] rgb_in,
  input  logic [rgb2y_pix_pkg::SB_W-1:0]     sb_in,
  output logic                               in_ready,
  // output luma stream
  output logic                               out_valid,
  input  logic                               out_ready,
  output logic [rgb2y_pix_pkg::Y_W-1:0]      y_out,
  output logic [rgb2y_pix_pkg::SB_W-1:0]     sb_out,
  // register port
  input  logic                               cfg_we,
  input  rgb2y_cfg_pkg::cfg_addr_e           cfg_addr,
  input  logic [rgb2y_cfg_pkg::CFG_DW-1:0]   cfg_wdata,
  output logic [rgb2y_cfg_pkg::CFG_DW-1:0]   cfg_rdata
);

  import rgb2y_pix_pkg::*;

  // --------------------
  // settings
  // --------------------
  pix_fmt_e        fmt;
  logic            clip_en;
  logic [Y_W-1:0]  clip_min;
  logic [Y_W-1:0]  clip_max;
  logic            stall_pulse;

  // unpack to weight_sum
  logic            ch_valid;
  logic            ch_ready;
  logic [CH_W-1:0] r8;
  logic [CH_W-1:0] g8;
  logic [CH_W-1:0] b8;
  logic [SB_W-1:0] ch_sb;

  // weight_sum to out_pack
  logic            y_valid;
  logic            y_ready;
  logic [Y_W-1:0]  y10;
  logic [SB_W-1:0] y_sb;

  rgb2y_cfg_regs u_cfg_regs (
    .clk         (clk),
    .arst_n      (arst_n),
    .cfg_we      (cfg_we),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .stall_pulse (stall_pulse),
    .pix_valid   (pix_valid),
    .in_ready    (in_ready),
    .cfg_rdata   (cfg_rdata),
    .fmt         (fmt),
    .clip_en     (clip_en),
    .clip_min    (clip_min),
    .clip_max    (clip_max)
  );

  // --------------------
  // pipeline chain
  // --------------------
  // 1 cycle unpack
  rgb2y_unpack u_unpack (
    .clk       (clk),
    .arst_n    (arst_n),
    .pix_valid (pix_valid),
    .rgb_in    (rgb_in),
    .sb_in     (sb_in),
    .fmt       (fmt),
    .ch_ready  (ch_ready),
    .in_ready  (in_ready),
    .ch_valid  (ch_valid),
    .r8        (r8),
    .g8        (g8),
    .b8        (b8),
    .ch_sb     (ch_sb)
  );

  // 2 cycles products and sum
  rgb2y_weight_sum u_weight_sum (
    .clk      (clk),
    .arst_n   (arst_n),
    .ch_valid (ch_valid),
    .r8       (r8),
    .g8       (g8),
    .b8       (b8),
    .ch_sb    (ch_sb),
    .y_ready  (y_ready),
    .ch_ready (ch_ready),
    .y_valid  (y_valid),
    .y10      (y10),
    .y_sb     (y_sb)
  );

  // 1 cycle through the buffer
  rgb2y_out_pack u_out_pack (
    .clk         (clk),
    .arst_n      (arst_n),
    .y_valid     (y_valid),
    .y10         (y10),
    .y_sb        (y_sb),
    .clip_en     (clip_en),
    .clip_min    (clip_min),
    .clip_max    (clip_max),
    .out_ready   (out_ready),
    .y_ready     (y_ready),
    .out_valid   (out_valid),
    .y_out       (y_out),
    .sb_out      (sb_out),
    .stall_pulse (stall_pulse)
  );

endmodule

//--- rgb2y_luma/rgb2y_out_pack.sv
// rgb2y output pack: optional clip window and two-entry elastic output buffer
`timescale 1ns/100ps

module rgb2y_out_pack (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           y_valid,
  input  logic [rgb2y_pix_pkg::Y_W-1:0]  y10,
  input  logic [rgb2y_pix_pkg::SB_W-1:0] y_sb,
  input  logic                           clip_en,
  input  logic [rgb2y_pix_pkg::Y_W-1:0]  clip_min,
  input  logic [rgb2y_pix_pkg::Y_W-1:0]  clip_max,
  input  logic                           out_ready,
  output logic                           y_ready,
  output logic                           out_valid,
  output logic [rgb2y_pix_pkg::Y_W-1:0]  y_out,
  output logic [rgb2y_pix_pkg::SB_W-1:0] sb_out,
  output logic                           stall_pulse
);

  import rgb2y_pix_pkg::*;

  // clip path
  logic [Y_W-1:0]  y_lo;
  logic [Y_W-1:0]  y_clip;

  // fifo storage, no reset
  logic [Y_W-1:0]  mem_y  [2];
  logic [SB_W-1:0] mem_sb [2];

  // fifo control
  logic            wr_ptr;
  logic            rd_ptr;
  logic [1:0]      cnt_q;
  logic            wr_en;
  logic            rd_en;

  // --------------------
  // clip window
  // --------------------
  // raise to min first, then lower to max
  assign y_lo   = (clip_en && (y10 < clip_min)) ? clip_min : y10;
  assign y_clip = (clip_en && (y_lo > clip_max)) ? clip_max : y_lo;

  // --------------------
  // handshakes
  // --------------------
  // room while not holding two
  assign y_ready     = (cnt_q != 2'd2);
  assign out_valid   = (cnt_q != 2'd0);
  assign wr_en       = y_valid && y_ready;
  assign rd_en       = out_valid && out_ready;
  assign stall_pulse = out_valid && !out_ready;

  // head of the fifo straight to the port
  assign y_out  = mem_y[rd_ptr];
  assign sb_out = mem_sb[rd_ptr];

  // --------------------
  // fifo control
  // --------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      cnt_q  <= 2'd0;
    end else begin
      if (wr_en) begin
        wr_ptr <= !wr_ptr;
      end
      if (rd_en) begin
        rd_ptr <= !rd_ptr;
      end
      // simultaneous read and write keeps the count
      case ({wr_en, rd_en})
        2'b10:   cnt_q <= cnt_q + 2'd1;
        2'b01:   cnt_q <= cnt_q - 2'd1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // data write, clipped value with its sideband
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_y[wr_ptr]  <= y_clip;
      mem_sb[wr_ptr] <= y_sb;
    end
  end

  // full and not draining: nothing may be written
  a_no_wr_full : assert property (@(posedge clk) disable iff (!arst_n)
    (cnt_q == 2'd2 && !rd_en) |=> (cnt_q == 2'd2 && $stable(wr_ptr)));

  // stalled output stays presented
  a_valid_hold : assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> out_valid);

endmodule

//--- rgb2y_luma/rgb2y_weight_sum.sv
// rgb2y weight and sum: coefficient products, then rounded sum to 10-bit luma
`timescale 1ns/100ps

module rgb2y_weight_sum (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           ch_valid,
  input  logic [rgb2y_pix_pkg::CH_W-1:0] r8,
  input  logic [rgb2y_pix_pkg::CH_W-1:0] g8,
  input  logic [rgb2y_pix_pkg::CH_W-1:0] b8,
  input  logic [rgb2y_pix_pkg::SB_W-1:0] ch_sb,
  input  logic                           y_ready,
  output logic                           ch_ready,
  output logic                           y_valid,
  output logic [rgb2y_pix_pkg::Y_W-1:0]  y10,
  output logic [rgb2y_pix_pkg::SB_W-1:0] y_sb
);

  import rgb2y_pix_pkg::*;

  // stage 1 state
  logic              p_valid;
  logic [PROD_W-1:0] r_p;
  logic [PROD_W-1:0] g_p;
  logic [PROD_W-1:0] b_p;
  logic [SB_W-1:0]   p_sb;

  // stage 2 input side
  logic              s2_ready;
  logic [SUM_W-1:0]  sum17;
  logic [SUM_W-1:0]  sum_rnd;

  // ready chain, combinational back to unpack
  assign s2_ready = !y_valid || y_ready;
  assign ch_ready = !p_valid || s2_ready;

  // --------------------
  // valid bits
  // --------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      p_valid <= 1'b0;
      y_valid <= 1'b0;
    end else begin
      if (ch_ready) begin
        p_valid <= ch_valid;
      end
      if (s2_ready) begin
        y_valid <= p_valid;
      end
    end
  end

  // --------------------
  // stage 1: products
  // --------------------
  // 8x8 unsigned, fits 16 bits
  always_ff @(posedge clk) begin
    if (ch_valid && ch_ready) begin
      r_p  <= r8 * COEF_R;
      g_p  <= g8 * COEF_G;
      b_p  <= b8 * COEF_B;
      p_sb <= ch_sb;
    end
  end

  // --------------------
  // stage 2: sum, round
  // --------------------
  assign sum17   = SUM_W'(r_p) + SUM_W'(g_p) + SUM_W'(b_p);
  // add half lsb, max 65312 so no carry out of 17 bits
  assign sum_rnd = sum17 + SUM_W'(1 << (ROUND_SH - 1));

  always_ff @(posedge clk) begin
    if (p_valid && s2_ready) begin
      y10  <= sum_rnd[ROUND_SH +: Y_W];
      y_sb <= p_sb;
    end
  end

  // coefficients sum to 256, result can never pass 1020
  a_y_range : assert property (@(posedge clk) disable iff (!arst_n)
    y_valid |-> (y10 <= Y_W'(Y_MAX)));

endmodule

//--- rgb2y_luma/rgb2y_unpack.sv
// rgb2y unpack stage: extracts 8-bit R, G, B from the input word per selected format
`timescale 1ns/100ps

module rgb2y_unpack (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               pix_valid,
  input  logic [rgb2y_pix_pkg::RGB_IN_W-1:0] rgb_in,
  input  logic [rgb2y_pix_pkg::SB_W-1:0]     sb_in,
  input  rgb2y_pix_pkg::pix_fmt_e            fmt,
  input  logic                               ch_ready,
  output logic                               in_ready,
  output logic                               ch_valid,
  output logic [rgb2y_pix_pkg::CH_W-1:0]     r8,
  output logic [rgb2y_pix_pkg::CH_W-1:0]     g8,
  output logic [rgb2y_pix_pkg::CH_W-1:0]     b8,
  output logic [rgb2y_pix_pkg::SB_W-1:0]     ch_sb
);

  import rgb2y_pix_pkg::*;

  logic [CH_W-1:0] r_nxt;
  logic [CH_W-1:0] g_nxt;
  logic [CH_W-1:0] b_nxt;
  logic            load;

  // stage free, or its item leaves this cycle
  assign in_ready = !ch_valid || ch_ready;
  assign load     = pix_valid && in_ready;

  // --------------------
  // field extraction
  // --------------------
  always_comb begin
    case (fmt)
      FMT_RGB565: begin
        // widen 5/6 bit fields, top bits repeated into the lsbs
        r_nxt = {rgb_in[15:11], rgb_in[15:13]};
        g_nxt = {rgb_in[10:5], rgb_in[10:9]};
        b_nxt = {rgb_in[4:0], rgb_in[4:2]};
      end
      FMT_RGB101010: begin
        // keep top 8 of each 10 bit field
        r_nxt = rgb_in[29:22];
        g_nxt = rgb_in[19:12];
        b_nxt = rgb_in[9:2];
      end
      default: begin
        // rgb888 in the low 24 bits
        r_nxt = rgb_in[23:16];
        g_nxt = rgb_in[15:8];
        b_nxt = rgb_in[7:0];
      end
    endcase
  end

  // --------------------
  // stage register
  // --------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ch_valid <= 1'b0;
    end else if (in_ready) begin
      ch_valid <= pix_valid;
    end
  end

  // payload, loaded only on accept
  always_ff @(posedge clk) begin
    if (load) begin
      r8    <= r_nxt;
      g8    <= g_nxt;
      b8    <= b_nxt;
      ch_sb <= sb_in;
    end
  end

  // stalled item must hold until weight_sum takes it
  a_hold_on_stall : assert property (@(posedge clk) disable iff (!arst_n)
    (ch_valid && !ch_ready) |=> (ch_valid && $stable(r8)));

endmodule

//--- logic/rgb2y_cfg_regs.sv
// rgb2y config registers: format and clip settings, stall and pixel counters
`timescale 1ns/100ps

module rgb2y_cfg_regs (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                cfg_we,
  input  rgb2y_cfg_pkg::cfg_addr_e            cfg_addr,
  input  logic [rgb2y_cfg_pkg::CFG_DW-1:0]    cfg_wdata,
  input  logic                                stall_pulse,
  input  logic                                pix_valid,
  input  logic                                in_ready,
  output logic [rgb2y_cfg_pkg::CFG_DW-1:0]    cfg_rdata,
  output rgb2y_pix_pkg::pix_fmt_e             fmt,
  output logic                                clip_en,
  output logic [rgb2y_pix_pkg::Y_W-1:0]       clip_min,
  output logic [rgb2y_pix_pkg::Y_W-1:0]       clip_max
);

  import rgb2y_pix_pkg::*;
  import rgb2y_cfg_pkg::*;

  logic [CNT_W-1:0] stall_cnt;
  logic [CNT_W-1:0] pix_cnt;

  // --------------------
  // settings
  // --------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fmt      <= FMT_RGB888;
      clip_en  <= 1'b0;
      clip_min <= Y_W'(CLIP_MIN_RST);
      clip_max <= Y_W'(CLIP_MAX_RST);
    end else if (cfg_we) begin
      case (cfg_addr)
        REG_FMT:      fmt      <= pix_fmt_e'(cfg_wdata[1:0]);
        REG_CLIP_EN:  clip_en  <= cfg_wdata[0];
        REG_CLIP_MIN: clip_min <= cfg_wdata[Y_W-1:0];
        REG_CLIP_MAX: clip_max <= cfg_wdata[Y_W-1:0];
        default: ;
      endcase
    end
  end

  // --------------------
  // counters
  // --------------------
  // write to own address clears, clear beats increment
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stall_cnt <= '0;
      pix_cnt   <= '0;
    end else begin
      if (cfg_we && cfg_addr == REG_STALL_CNT) begin
        stall_cnt <= '0;
      end else if (stall_pulse) begin
        stall_cnt <= stall_cnt + 1'b1;
      end
      // accepted input beats
      if (cfg_we && cfg_addr == REG_PIX_CNT) begin
        pix_cnt <= '0;
      end else if (pix_valid && in_ready) begin
        pix_cnt <= pix_cnt + 1'b1;
      end
    end
  end

  // read mux, settings zero-extended
  always_comb begin
    case (cfg_addr)
      REG_FMT:       cfg_rdata = CFG_DW'(fmt);
      REG_CLIP_EN:   cfg_rdata = CFG_DW'(clip_en);
      REG_CLIP_MIN:  cfg_rdata = CFG_DW'(clip_min);
      REG_CLIP_MAX:  cfg_rdata = CFG_DW'(clip_max);
      REG_STALL_CNT: cfg_rdata = CFG_DW'(stall_cnt);
      REG_PIX_CNT:   cfg_rdata = CFG_DW'(pix_cnt);
      default:       cfg_rdata = '0;
    endcase
  end

endmodule

//--- common/rgb2y_cfg_pkg.sv
// rgb2y config package: register map, register widths and reset values
package rgb2y_cfg_pkg;

  // --------------------
  // register map
  // --------------------
  typedef enum logic [2:0] {
    // pixel format select, 2 bits
    REG_FMT       = 3'd0,
    // clip enable, 1 bit
    REG_CLIP_EN   = 3'd1,
    // window bounds, 10 bits each
    REG_CLIP_MIN  = 3'd2,
    REG_CLIP_MAX  = 3'd3,
    // counters, any write clears
    REG_STALL_CNT = 3'd4,
    REG_PIX_CNT   = 3'd5
  } cfg_addr_e;

  // --------------------
  // widths and resets
  // --------------------
  // register data bus
  localparam int unsigned CFG_DW = 16;
  // stall and pixel counters, wrap on overflow
  localparam int unsigned CNT_W  = 16;

  // window is fully open after reset
  localparam int unsigned CLIP_MIN_RST = 0;
  localparam int unsigned CLIP_MAX_RST = 1023;

endpackage

//--- common/rgb2y_pix_pkg.sv
// rgb2y pixel package: pixel formats, datapath widths and BT.601 luma coefficients
package rgb2y_pix_pkg;

  // --------------------
  // input pixel formats
  // --------------------
  // value 3 is unused and unpacks as RGB888
  typedef enum logic [1:0] {
    FMT_RGB888    = 2'd0,
    FMT_RGB565    = 2'd1,
    FMT_RGB101010 = 2'd2
  } pix_fmt_e;

  // --------------------
  // datapath widths
  // --------------------
  // raw input word, wide enough for 3x10 bit plus spare
  localparam int unsigned RGB_IN_W = 36;
  // unpacked channel
  localparam int unsigned CH_W     = 8;
  // one channel times one coefficient
  localparam int unsigned PROD_W   = 16;
  // sum of three products, max 255*256
  localparam int unsigned SUM_W    = 17;
  // luma result
  localparam int unsigned Y_W      = 10;
  // sideband, sof and eol
  localparam int unsigned SB_W     = 2;

  // --------------------
  // BT.601 weights
  // --------------------
  // 77 + 150 + 29 = 256, so white maps to 255*256
  localparam logic [7:0] COEF_R = 8'd77;
  localparam logic [7:0] COEF_G = 8'd150;
  localparam logic [7:0] COEF_B = 8'd29;

  // sum to 10 bit luma: drop 6 lsbs with round half up
  localparam int unsigned ROUND_SH = 6;
  // largest luma the rounding can give
  localparam int unsigned Y_MAX    = 1020;

endpackage
